//--- hdl/cart_types_pkg.sv
/*
	Cartridge type codes and the vector widths used by the bank logic.
	Imported by the bank table, the bank controller, the bank state
	interface and the top level.
*/
`default_nettype none

package cart_types_pkg;

	typedef logic [15:0] word_t;     // CRT header fields and cart type code
	typedef logic [6:0]  bank_t;     // 8K bank number
	typedef logic [5:0]  slot_t;     // Bank table index
	typedef logic [7:0]  cdata_t;    // CPU data bus
	typedef logic [7:0]  bank_cnt_t; // Chip packets seen since load start

	// Hardware types handled by the mapper, codes as in the CRT header.
	// Any other code leaves the bank state at its reset values
	typedef enum logic [15:0] {
		CART_GENERIC    = 16'd0,
		CART_SIMONS     = 16'd4,
		CART_OCEAN      = 16'd5,
		CART_C64GS      = 16'd15,
		CART_MAGIC_DESK = 16'd19,
		CART_EASYFLASH  = 16'd32
	} cart_id_t;

	// Bank table geometry
	localparam int    TABLE_DEPTH      = 64;
	localparam word_t LOW_WINDOW_LIMIT = 16'h8000; // Highest load address for ROML
	localparam word_t BANK_SPLIT_SIZE  = 16'h2000; // Bigger packets spill into ROMH

	// Magic Desk bank mask steps, by number of packets loaded
	localparam bank_cnt_t MD_CNT_4BIT = 8'd16;
	localparam bank_cnt_t MD_CNT_5BIT = 8'd32;
	localparam bank_cnt_t MD_CNT_6BIT = 8'd64;

endpackage

`default_nettype wire

//--- hdl/cart_map_pkg.sv
/*
	SDRAM address map of the cartridge image.
	ROM banks live at 0x100000 in 8K pages, cartridge RAM at 0x040000.
	Imported wherever a CPU or SDRAM address is carried.
*/
`default_nettype none

package cart_map_pkg;

	localparam int SDRAM_AW = 25;  // SDRAM byte address width
	localparam int CPU_AW   = 18;  // CPU side address width
	localparam int PAGE_LSB = 13;  // 8K pages

	typedef logic [SDRAM_AW-1:0]          sdram_addr_t;
	typedef logic [CPU_AW-1:0]            cpu_addr_t;
	typedef logic [SDRAM_AW-PAGE_LSB-1:0] page_t;      // Address bits 24..13

	// ROM page is {1, bank[6:0]} giving base 0x100000
	localparam logic [0:0] ROM_PAGE_PREFIX = 1'b1;

	// RAM page is {00100, bank[2:0]} giving base 0x040000, 64K max
	localparam logic [4:0] RAM_PAGE_PREFIX = 5'b00100;
	localparam int         RAM_BANK_BITS   = 3;

endpackage

`default_nettype wire

//--- hdl/bank_state_if.sv
/*
	Current bank selection and line overrides, passed from the bank
	controller to the address translator. The controller owns every
	signal, the translator only reads them.
*/
`timescale 1ns/1ps
`default_nettype none

interface bank_state_if
	import cart_types_pkg::*;
();

	bank_t bank_lo;     // ROML bank
	bank_t bank_hi;     // ROMH bank
	bank_t ioe_bank;    // Bank mirrored into DExx
	bank_t iof_bank;    // Bank mirrored into DFxx
	logic  ioe_ena;     // DExx reads go to SDRAM
	logic  iof_ena;     // DFxx reads go to SDRAM
	logic  iof_wr_ena;  // DFxx is cartridge RAM
	logic  exrom_ovr;
	logic  game_ovr;

	modport ctrl (
		output bank_lo, bank_hi, ioe_bank, iof_bank,
		output ioe_ena, iof_ena, iof_wr_ena,
		output exrom_ovr, game_ovr
	);

	modport xlat (
		input bank_lo, bank_hi, ioe_bank, iof_bank,
		input ioe_ena, iof_ena, iof_wr_ena,
		input exrom_ovr, game_ovr
	);

endinterface

`default_nettype wire

//--- hdl/bank_table.sv
/*
	Bank table filled from the CRT chip packets while the image loads.
	Each packet records where its data sits in SDRAM, in the low table
	for ROML or the high table for ROMH. Lookup by slot is combinational.
*/
`timescale 1ns/1ps
`default_nettype none

module bank_table
	import cart_types_pkg::*;
	import cart_map_pkg::*;
(
	input  wire         clk32,
	input  wire         cart_loading,   // High while the CRT image loads
	input  wire         cart_bank_wr,   // One cycle per chip packet
	input  word_t       cart_bank_num,  // Bank number from the packet header
	input  word_t       cart_bank_laddr,// Load address, 0x8000 or 0xA000 / 0xE000
	input  word_t       cart_bank_size, // Packet data size
	input  sdram_addr_t cart_bank_raddr,// Where the packet data went in SDRAM
	input  slot_t       lookup_slot,
	output bank_t       lookup_lo,
	output bank_t       lookup_hi,
	output bank_cnt_t   bank_cnt
);

	bank_t lo_tbl [TABLE_DEPTH];
	bank_t hi_tbl [TABLE_DEPTH];

	logic  loading_q;
	slot_t wr_slot;
	bank_t wr_bank;
	logic  wr_ok;

	assign wr_slot = slot_t'(cart_bank_num);
	assign wr_bank = cart_bank_raddr[PAGE_LSB +: $bits(bank_t)]; // Bits 19..13
	assign wr_ok   = cart_bank_wr && (cart_bank_num < TABLE_DEPTH);

	// *********************************************************************
	// Packet counter, restarted when a new image starts loading
	// *********************************************************************
	always_ff @(posedge clk32) begin
		loading_q <= cart_loading;
		if (cart_loading && !loading_q) begin
			bank_cnt <= '0;
		end
		if (cart_bank_wr) begin
			bank_cnt <= bank_cnt + 1'b1;
		end
	end

	// *********************************************************************
	// Table writes
	// *********************************************************************
	always_ff @(posedge clk32) begin
		if (wr_ok) begin
			if (cart_bank_laddr <= LOW_WINDOW_LIMIT) begin
				lo_tbl[wr_slot] <= wr_bank;
				// 16K packet, upper half belongs to ROMH
				if (cart_bank_size > BANK_SPLIT_SIZE) begin
					hi_tbl[wr_slot] <= wr_bank + 1'b1;
				end
			end else begin
				hi_tbl[wr_slot] <= wr_bank;    // ROMH only or Ultimax packet
			end
		end
	end

	assign lookup_lo = lo_tbl[lookup_slot];
	assign lookup_hi = hi_tbl[lookup_slot];

endmodule

`default_nettype wire

//--- hdl/bank_controller.sv
/*
	Bank switching registers of the supported cartridge types.
	Watches the IOE and IOF selects for new accesses and updates the
	bank selection and the EXROM/GAME overrides by the rules of the
	current cartridge type. A type change restarts the type's setup.
*/
`timescale 1ns/1ps
`default_nettype none

module bank_controller
	import cart_types_pkg::*;
	import cart_map_pkg::*;
(
	input  wire       clk32,
	input  wire       reset_n,
	input  word_t     cart_id,
	input  cdata_t    cart_exrom,   // EXROM level from the CRT header
	input  cdata_t    cart_game,    // GAME level from the CRT header
	input  wire       ioe,
	input  wire       iof,
	input  wire       mem_write,
	input  cpu_addr_t addr_in,
	input  cdata_t    data_in,
	input  bank_t     lookup_lo,
	input  bank_t     lookup_hi,
	input  bank_cnt_t bank_cnt,
	output slot_t     lookup_slot,
	bank_state_if.ctrl st
);

	// *********************************************************************
	// IO select edges
	// *********************************************************************
	logic [1:0] sel_q;    // {iof, ioe} one clock back
	logic [1:0] sel_rise;
	logic       ioe_wr;
	logic       ioe_rd;

	always_ff @(posedge clk32) begin
		sel_q <= {iof, ioe};
	end

	assign sel_rise = {iof, ioe} & ~sel_q;
	assign ioe_wr   = sel_rise[0] & mem_write;
	assign ioe_rd   = sel_rise[0] & ~mem_write;

	logic  init_done;     // Low for one clock after reset or type change
	word_t old_id;
	logic  ef_bank_wr;    // EasyFlash bank register write at DE00

	assign ef_bank_wr = init_done && ioe_wr && !addr_in[1] &&
	                    (cart_id == CART_EASYFLASH);

	// Slot 0 unless EasyFlash selects a new bank
	always_comb begin
		lookup_slot = '0;
		if (ef_bank_wr) begin
			lookup_slot = data_in[5:0];
		end
	end

	// *********************************************************************
	// Bank registers
	// *********************************************************************
	always_ff @(posedge clk32) begin
		init_done <= 1'b1;
		old_id    <= cart_id;

		if (reset_n || (old_id != cart_id)) begin
			st.bank_lo    <= '0;
			st.bank_hi    <= '0;
			st.ioe_bank   <= '0;
			st.iof_bank   <= '0;
			st.ioe_ena    <= 1'b0;
			st.iof_ena    <= 1'b0;
			st.iof_wr_ena <= 1'b0;
			st.exrom_ovr  <= 1'b1;    // Cartridge lines released
			st.game_ovr   <= 1'b1;
			init_done     <= 1'b0;
		end else begin
			case (cart_id)
				// 8K, 16K or Ultimax as the header says
				CART_GENERIC: begin
					st.exrom_ovr <= cart_exrom[0];
					st.game_ovr  <= cart_game[0];
					st.bank_lo   <= lookup_lo;
					st.bank_hi   <= lookup_hi;
				end

				// 16K at start, IOE read drops to 8K, IOE write back to 16K
				CART_SIMONS: begin
					if (!init_done) begin
						st.exrom_ovr <= 1'b0;
						st.game_ovr  <= 1'b0;
						st.bank_lo   <= bank_t'(0);
						st.bank_hi   <= bank_t'(1);
					end
					if (ioe_wr) st.game_ovr <= 1'b0;
					if (ioe_rd) st.game_ovr <= 1'b1;
				end

				// Same bank mirrored at 8000 and A000
				CART_OCEAN: begin
					st.exrom_ovr <= 1'b0;
					st.game_ovr  <= 1'b0;
					if (ioe_wr) begin
						st.bank_lo <= bank_t'(data_in[5:0]);
						st.bank_hi <= bank_t'(data_in[5:0]);
					end
				end

				// 8K mode, bank comes from the written IO address
				CART_C64GS: begin
					st.exrom_ovr <= 1'b0;
					st.game_ovr  <= 1'b1;
					if (ioe_rd) st.bank_lo <= '0;
					if (ioe_wr) st.bank_lo <= bank_t'(addr_in[5:0]);
				end

				CART_MAGIC_DESK: begin
					if (!init_done) begin
						st.exrom_ovr <= 1'b0;
						st.game_ovr  <= 1'b1;
						st.bank_lo   <= '0;
					end
					if (ioe_wr) begin
						// Mask by image size so short images wrap
						if (bank_cnt <= MD_CNT_4BIT) begin
							st.bank_lo <= bank_t'(data_in[3:0]);
						end else if (bank_cnt <= MD_CNT_5BIT) begin
							st.bank_lo <= bank_t'(data_in[4:0]);
						end else if (bank_cnt <= MD_CNT_6BIT) begin
							st.bank_lo <= bank_t'(data_in[5:0]);
						end else begin
							st.bank_lo <= data_in[6:0];
						end
						st.exrom_ovr <= data_in[7];  // Bit 7 hides the cartridge
					end
				end

				// Boots in Ultimax, 256 bytes of RAM at DFxx
				CART_EASYFLASH: begin
					if (!init_done) begin
						st.iof_bank   <= '0;
						st.iof_ena    <= 1'b1;
						st.iof_wr_ena <= 1'b1;
						st.exrom_ovr  <= 1'b1;
						st.game_ovr   <= 1'b0;
						st.bank_lo    <= lookup_lo;
						st.bank_hi    <= lookup_hi;
					end
					if (ioe_wr && addr_in[1]) begin  // DE02 control
						st.game_ovr  <= ~data_in[0] & data_in[2];
						st.exrom_ovr <= ~data_in[1];
					end
					if (ef_bank_wr) begin            // DE00 bank
						st.bank_lo <= lookup_lo;
						st.bank_hi <= lookup_hi;
					end
				end

				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/addr_translate.sv
/*
	Maps CPU accesses in the cartridge windows onto the SDRAM image.
	Purely combinational, driven by the bank state of the controller.
	Also gates the memory enable and write strobe toward SDRAM.
*/
`timescale 1ns/1ps
`default_nettype none

module addr_translate
	import cart_types_pkg::*;
	import cart_map_pkg::*;
(
	input  wire         rom_l,
	input  wire         rom_h,
	input  wire         ioe,
	input  wire         iof,
	input  wire         mem_write,
	input  wire         mem_ce,
	input  cpu_addr_t   addr_in,
	bank_state_if.xlat  st,
	output logic        exrom,
	output logic        game,
	output logic        mem_ce_out,
	output logic        mem_write_out,
	output sdram_addr_t addr_out
);

	logic cs_ioe;
	logic cs_iof;

	function automatic page_t rom_page(input bank_t bank);
		rom_page = page_t'({ROM_PAGE_PREFIX, bank});
	endfunction

	function automatic page_t ram_page(input bank_t bank);
		ram_page = page_t'({RAM_PAGE_PREFIX, bank[RAM_BANK_BITS-1:0]});
	endfunction

	assign exrom = st.exrom_ovr;
	assign game  = st.game_ovr;

	// DExx has no RAM on the kept types, so only reads select it
	assign cs_ioe = ioe && !mem_write && st.ioe_ena;
	assign cs_iof = iof && (mem_write ? st.iof_wr_ena : st.iof_ena);

	assign mem_ce_out = mem_ce | cs_ioe | cs_iof;

	// No RAM under ROML in Ultimax mode
	assign mem_write_out = mem_write & ~(rom_l & st.exrom_ovr & ~st.game_ovr);

	// *********************************************************************
	// Address redirection, later windows take priority
	// *********************************************************************
	always_comb begin
		addr_out = sdram_addr_t'(addr_in);
		if (rom_h && !mem_write) begin
			addr_out[SDRAM_AW-1:PAGE_LSB] = rom_page(st.bank_hi);
		end
		if (rom_l && !mem_write) begin
			addr_out[SDRAM_AW-1:PAGE_LSB] = rom_page(st.bank_lo);
		end
		if (cs_ioe) begin
			addr_out[SDRAM_AW-1:PAGE_LSB] = rom_page(st.ioe_bank);  // DExx
		end
		if (cs_iof) begin
			addr_out[SDRAM_AW-1:PAGE_LSB] = st.iof_wr_ena ? ram_page(st.iof_bank)
			                                              : rom_page(st.iof_bank);
		end
	end

endmodule

`default_nettype wire

//--- hdl/cartridge_top.sv
/*
	Cartridge bank mapper top level.
	Bank table, bank controller and address translator in a chain,
	the bank state passed through one interface.
*/
`timescale 1ns/1ps
`default_nettype none

module cartridge_top
	import cart_types_pkg::*;
	import cart_map_pkg::*;
(
	input  wire         clk32,
	input  wire         reset_n,
	input  wire         cart_loading,
	input  word_t       cart_id,
	input  cdata_t      cart_exrom,
	input  cdata_t      cart_game,
	input  word_t       cart_bank_laddr,
	input  word_t       cart_bank_size,
	input  word_t       cart_bank_num,
	input  sdram_addr_t cart_bank_raddr,
	input  wire         cart_bank_wr,
	input  wire         rom_l,
	input  wire         rom_h,
	input  wire         ioe,
	input  wire         iof,
	input  wire         mem_write,
	input  wire         mem_ce,
	input  cpu_addr_t   addr_in,
	input  cdata_t      data_in,
	output wire         exrom,
	output wire         game,
	output wire         mem_ce_out,
	output wire         mem_write_out,
	output sdram_addr_t addr_out
);

	slot_t     lookup_slot;
	bank_t     lookup_lo;
	bank_t     lookup_hi;
	bank_cnt_t bank_cnt;

	bank_state_if bank_st ();

	bank_table table0 (
		.clk32           (clk32),
		.cart_loading    (cart_loading),
		.cart_bank_wr    (cart_bank_wr),
		.cart_bank_num   (cart_bank_num),
		.cart_bank_laddr (cart_bank_laddr),
		.cart_bank_size  (cart_bank_size),
		.cart_bank_raddr (cart_bank_raddr),
		.lookup_slot     (lookup_slot),
		.lookup_lo       (lookup_lo),
		.lookup_hi       (lookup_hi),
		.bank_cnt        (bank_cnt)
	);

	bank_controller ctrl0 (
		.clk32       (clk32),
		.reset_n     (reset_n),
		.cart_id     (cart_id),
		.cart_exrom  (cart_exrom),
		.cart_game   (cart_game),
		.ioe         (ioe),
		.iof         (iof),
		.mem_write   (mem_write),
		.addr_in     (addr_in),
		.data_in     (data_in),
		.lookup_lo   (lookup_lo),
		.lookup_hi   (lookup_hi),
		.bank_cnt    (bank_cnt),
		.lookup_slot (lookup_slot),
		.st          (bank_st.ctrl)
	);

	addr_translate xlat0 (
		.rom_l         (rom_l),
		.rom_h         (rom_h),
		.ioe           (ioe),
		.iof           (iof),
		.mem_write     (mem_write),
		.mem_ce        (mem_ce),
		.addr_in       (addr_in),
		.st            (bank_st.xlat),
		.exrom         (exrom),
		.game          (game),
		.mem_ce_out    (mem_ce_out),
		.mem_write_out (mem_write_out),
		.addr_out      (addr_out)
	);

endmodule

`default_nettype wire

//--- dv/tb_cartridge.sv
/*
	Self-checking testbench of the cartridge bank mapper.
	Runs the operations of dv/cart_patterns.txt one line at a time and
	compares the mapper outputs with the expected values on each line.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_cartridge
	import cart_types_pkg::*;
	import cart_map_pkg::*;
();

	localparam int WAIT_LIMIT = 16;  // Clocks allowed for a type setup to show

	logic        clk32;
	logic        reset_n;
	logic        cart_loading;
	word_t       cart_id;
	cdata_t      cart_exrom;
	cdata_t      cart_game;
	word_t       cart_bank_laddr;
	word_t       cart_bank_size;
	word_t       cart_bank_num;
	sdram_addr_t cart_bank_raddr;
	logic        cart_bank_wr;
	logic        rom_l;
	logic        rom_h;
	logic        ioe;
	logic        iof;
	logic        mem_write;
	logic        mem_ce;
	cpu_addr_t   addr_in;
	cdata_t      data_in;
	wire         exrom;
	wire         game;
	wire         mem_ce_out;
	wire         mem_write_out;
	sdram_addr_t addr_out;

	int checks;
	int errors;
	int timeouts;

	cartridge_top dut0 (.*);

	initial begin
		clk32 = 1'b0;
		forever #10 clk32 = ~clk32;
	end

	// **********************************************************************
	// Helper tasks return on a falling edge or mid low phase
	// **********************************************************************
	task automatic compare_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic next_clock();
		@(posedge clk32);
		@(negedge clk32);
	endtask

	task automatic check_lines(input string name, input logic [31:0] ex, input logic [31:0] gm);
		compare_value({name, " exrom"}, ex, {31'd0, exrom});
		compare_value({name, " game"}, gm, {31'd0, game});
	endtask

	task automatic hold_reset();
		reset_n = 1'b1;
		repeat (3) next_clock();
		reset_n = 1'b0;
	endtask

	task automatic load_packet(input logic [31:0] num, input logic [31:0] laddr,
		input logic [31:0] size, input logic [31:0] raddr);
		cart_bank_num   = num[15:0];
		cart_bank_laddr = laddr[15:0];
		cart_bank_size  = size[15:0];
		cart_bank_raddr = raddr[24:0];
		cart_bank_wr    = 1'b1;
		next_clock();
		cart_bank_wr    = 1'b0;
	endtask

	// Lets the type setup settle for at least one clock
	task automatic wait_for_lines(input int lineno, input logic [31:0] ex,
		input logic [31:0] gm);
		int n;
		n = 0;
		next_clock();
		while ({exrom, game} !== {ex[0], gm[0]} && n < WAIT_LIMIT) begin
			next_clock();
			n++;
		end
		if ({exrom, game} !== {ex[0], gm[0]}) begin
			timeouts++;
			$display("Line %0d: exrom and game did not reach %b %b within %0d clocks",
				lineno, ex[0], gm[0], WAIT_LIMIT);
		end
	endtask

	task automatic io_access(input int lineno, input logic [31:0] sel, wr, addr, data,
		input logic [31:0] ex, gm, ad, ce);
		ioe       = ~sel[0];
		iof       = sel[0];
		mem_write = wr[0];
		mem_ce    = 1'b0;
		addr_in   = addr[17:0];
		data_in   = data[7:0];
		#5;
		compare_value($sformatf("line %0d io addr_out", lineno), ad, {7'd0, addr_out});
		compare_value($sformatf("line %0d io mem_ce_out", lineno), ce, {31'd0, mem_ce_out});
		compare_value($sformatf("line %0d io mem_write_out", lineno), {31'd0, wr[0]},
			{31'd0, mem_write_out});
		next_clock();     // Select edge taken here
		check_lines($sformatf("line %0d io", lineno), ex, gm);
		ioe       = 1'b0;
		iof       = 1'b0;
		mem_write = 1'b0;
		next_clock();     // Select low again before the next access
	endtask

	task automatic probe_read(input int lineno, input logic [31:0] win, addr,
		input logic [31:0] ex, gm, ad, ce);
		logic wr_exp;
		rom_l     = ~win[0];
		rom_h     = win[0];
		mem_write = 1'b0;
		mem_ce    = 1'b1;
		addr_in   = addr[17:0];
		#5;
		compare_value($sformatf("line %0d probe addr_out", lineno), ad, {7'd0, addr_out});
		compare_value($sformatf("line %0d probe mem_ce_out", lineno), ce,
			{31'd0, mem_ce_out});
		check_lines($sformatf("line %0d probe", lineno), ex, gm);
		next_clock();
		// Same window written, ROML stays read-only in Ultimax mode
		wr_exp    = ~(~win[0] & ex[0] & ~gm[0]);
		mem_write = 1'b1;
		#5;
		compare_value($sformatf("line %0d probe mem_write_out", lineno), {31'd0, wr_exp},
			{31'd0, mem_write_out});
		next_clock();
		rom_l     = 1'b0;
		rom_h     = 1'b0;
		mem_write = 1'b0;
		mem_ce    = 1'b0;
	endtask

	task automatic run_line(input int lineno, input string op, input logic [31:0] a, b, c, d,
		input logic [31:0] ex, gm, ad, ce);
		if (op == "start") begin
			cart_loading = 1'b0;
			next_clock();
			cart_loading = 1'b1;    // Rising edge clears the bank count
			next_clock();
		end else if (op == "pkt") begin
			load_packet(a, b, c, d);
		end else if (op == "burst") begin
			for (int i = 0; i < b; i++) begin
				load_packet(a + i, 32'h8000, 32'h2000, c + i * 32'h2000);
			end
		end else if (op == "type") begin
			cart_id    = a[15:0];
			cart_exrom = b[7:0];
			cart_game  = c[7:0];
			next_clock();           // Bank state cleared on this clock
			check_lines($sformatf("line %0d type", lineno), ex, gm);
		end else if (op == "wait") begin
			wait_for_lines(lineno, ex, gm);
		end else if (op == "rst") begin
			hold_reset();
			check_lines($sformatf("line %0d reset", lineno), ex, gm);
		end else if (op == "io") begin
			io_access(lineno, a, b, c, d, ex, gm, ad, ce);
		end else if (op == "probe") begin
			probe_read(lineno, a, b, ex, gm, ad, ce);
		end else begin
			errors++;
			$display("Line %0d: unknown operation %s", lineno, op);
		end
	endtask

	// **********************************************************************
	// Pattern file driver
	// **********************************************************************
	initial begin
		int          fd;
		int          n;
		int          lineno;
		string       line;
		string       op;
		logic [31:0] a, b, c, d, ex, gm, ad, ce;

		checks          = 0;
		errors          = 0;
		timeouts        = 0;
		reset_n         = 1'b1;
		cart_loading    = 1'b0;
		cart_id         = 16'hffff;   // No mapper until a type is set
		cart_exrom      = '0;
		cart_game       = '0;
		cart_bank_laddr = '0;
		cart_bank_size  = '0;
		cart_bank_num   = '0;
		cart_bank_raddr = '0;
		cart_bank_wr    = 1'b0;
		rom_l           = 1'b0;
		rom_h           = 1'b0;
		ioe             = 1'b0;
		iof             = 1'b0;
		mem_write       = 1'b0;
		mem_ce          = 1'b0;
		addr_in         = '0;
		data_in         = '0;
		hold_reset();

		fd = $fopen("dv/cart_patterns.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Cannot open the pattern file dv/cart_patterns.txt");
		end else begin
			lineno = 0;
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				lineno++;
				if (n > 0 && line.len() > 0 && line[0] != "#") begin
					n = $sscanf(line, "%s %h %h %h %h %h %h %h %h",
						op, a, b, c, d, ex, gm, ad, ce);
					if (n == 9) begin
						run_line(lineno, op, a, b, c, d, ex, gm, ad, ce);
					end else if (n > 0) begin
						errors++;
						$display("Line %0d of the pattern file is malformed", lineno);
					end
				end
			end
			$fclose(fd);
		end

		$display("Checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- dv/cart_patterns.txt
# op a b c d exrom game addr_out mem_ce_out, all hex. pkt: num laddr size raddr. burst: slot count raddr
# type: id exrom game. io: sel(0 IOE 1 IOF) write addr data. probe: win(0 ROML 1 ROMH) addr
start 0 0 0 0 0 0 0 0
pkt 0 8000 4000 104000 0 0 0 0
pkt 1 8000 2000 10a000 0 0 0 0
type 0 fe 1 0 1 1 0 0
wait 0 0 0 0 0 1 0 0
probe 0 9234 0 0 0 1 105234 1
probe 1 a010 0 0 0 1 106010 1
type 5 0 0 0 1 1 0 0
wait 0 0 0 0 0 0 0 0
io 0 1 de00 47 0 0 de00 0
probe 0 8005 0 0 0 0 10e005 1
probe 1 bfff 0 0 0 0 10ffff 1
start 0 0 0 0 0 0 0 0
burst 0 10 100000 0 0 0 0 0
type 13 0 0 0 1 1 0 0
wait 0 0 0 0 0 1 0 0
io 0 1 de00 1f 0 1 de00 0
probe 0 8000 0 0 0 1 11e000 1
burst 10 10 120000 0 0 0 0 0
io 0 1 de00 1f 0 1 de00 0
probe 0 8000 0 0 0 1 13e000 1
io 0 1 de00 9f 1 1 de00 0
probe 0 8100 0 0 1 1 13e100 1
start 0 0 0 0 0 0 0 0
pkt 0 8000 2000 100000 0 0 0 0
pkt 0 a000 2000 102000 0 0 0 0
pkt 1 8000 2000 104000 0 0 0 0
pkt 1 e000 2000 106000 0 0 0 0
type 20 0 0 0 1 1 0 0
wait 0 0 0 0 1 0 0 0
probe 0 8010 0 0 1 0 100010 1
probe 1 e010 0 0 1 0 102010 1
io 0 1 de00 1 1 0 de00 0
probe 0 8010 0 0 1 0 104010 1
probe 1 e010 0 0 1 0 106010 1
io 0 1 de02 7 0 0 de02 0
io 0 1 de02 5 1 0 de02 0
io 0 1 de02 4 1 1 de02 0
io 1 1 df10 aa 1 1 41f10 1
io 1 0 df10 0 1 1 41f10 1
type 4 0 0 0 1 1 0 0
wait 0 0 0 0 0 0 0 0
probe 1 a000 0 0 0 0 102000 1
io 0 0 de00 0 0 1 de00 0
io 0 1 de00 0 0 0 de00 0
type f 0 0 0 1 1 0 0
wait 0 0 0 0 0 1 0 0
io 0 1 de2a 0 0 1 de2a 0
probe 0 8000 0 0 0 1 154000 1
io 0 0 de00 0 0 1 de00 0
probe 0 8000 0 0 0 1 100000 1
rst 0 0 0 0 1 1 0 0
wait 0 0 0 0 0 1 0 0
probe 0 8000 0 0 0 1 100000 1

//--- all.f
hdl/cart_types_pkg.sv
hdl/cart_map_pkg.sv
hdl/bank_state_if.sv
hdl/bank_table.sv
hdl/bank_controller.sv
hdl/addr_translate.sv
hdl/cartridge_top.sv
dv/tb_cartridge.sv

//--- run_sim.sh
#!/bin/sh
# Builds the cartridge mapper testbench with Verilator and runs it.
# The pass line in sim.log decides the exit status.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_cartridge -f all.f -o tb_cartridge

./obj_dir/tb_cartridge > sim.log 2>&1
cat sim.log

if grep -q '^>>> PASS$' sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi
